// File: logic/blit_params.svh
`ifndef BLIT_PARAMS_SVH
`define BLIT_PARAMS_SVH

// framebuffer size in pixels
`define FB_WIDTH  400
`define FB_HEIGHT 240

// byte address and memory word widths
`define ADDR_W 32
`define WORD_W 32

`define COORD_W  16 // coordinates and sizes
`define COLOUR_W 16 // rgb565 colour or palette index

// shared read port is answered one cycle after the request
`define MEM_LATENCY 1

`endif

// File: logic/blit_pkg.sv
`include "blit_params.svh"

package blit_pkg;

    typedef logic [`COORD_W-1:0]  coord_t;
    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [`COLOUR_W-1:0] colour_t;

    // bits per pixel
    typedef enum logic [4:0] {
        DEPTH_1  = 5'd1,
        DEPTH_2  = 5'd2,
        DEPTH_4  = 5'd4,
        DEPTH_8  = 5'd8,
        DEPTH_16 = 5'd16
    } depth_t;

    typedef enum logic {
        W_IDLE,
        W_WALK
    } walk_state_t;

    typedef enum logic [1:0] {
        F_IDLE,
        F_READ,
        F_HOLD
    } fetch_state_t;

endpackage

// File: logic/rect_walker.sv
`timescale 1ns/1ns
`include "blit_params.svh"

module rect_walker import blit_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  coord_t src_x,
    input  coord_t src_y,
    input  coord_t dst_x,
    input  coord_t dst_y,
    input  coord_t width,
    input  coord_t height,
    input  logic   mirror_x,
    input  logic   mirror_y,
    input  logic   ready,
    output coord_t sx,
    output coord_t sy,
    output coord_t px,
    output coord_t py,
    output logic   valid,
    output logic   busy
);

    walk_state_t state;
    coord_t      src_x_r;
    coord_t      src_y_r;
    coord_t      dst_x_r;
    coord_t      dst_y_r;
    coord_t      width_r;
    coord_t      height_r;
    logic        mirror_x_r;
    logic        mirror_y_r;
    coord_t      col;
    coord_t      row;
    logic        last_col;
    logic        last_row;
    logic        in_bounds;
    logic        step;

    assign sx = src_x_r + col;
    assign sy = src_y_r + row;
    assign px = mirror_x_r ? dst_x_r + width_r - coord_t'(1) - col : dst_x_r + col;
    assign py = mirror_y_r ? dst_y_r + height_r - coord_t'(1) - row : dst_y_r + row;

    assign in_bounds = (px < `FB_WIDTH) && (py < `FB_HEIGHT); // wrapped coords land here too
    assign last_col  = col == width_r - coord_t'(1);
    assign last_row  = row == height_r - coord_t'(1);

    assign busy  = state == W_WALK;
    assign valid = busy && in_bounds;
    assign step  = busy && (ready || !in_bounds); // clipped pixels skip without a transfer

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: if (start && width != '0 && height != '0) state <= W_WALK;
                W_WALK: if (step && last_col && last_row) state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_IDLE) begin
            if (start) begin
                src_x_r    <= src_x;
                src_y_r    <= src_y;
                dst_x_r    <= dst_x;
                dst_y_r    <= dst_y;
                width_r    <= width;
                height_r   <= height;
                mirror_x_r <= mirror_x;
                mirror_y_r <= mirror_y;
                col        <= '0;
                row        <= '0;
            end
        end else if (step) begin
            if (last_col) begin
                col <= '0;
                row <= row + coord_t'(1);
            end else begin
                col <= col + coord_t'(1);
            end
        end
    end

    // offsets never leave the excerpt
    a_in_rect: assert property (@(posedge clk) disable iff (rst)
        busy |-> (col < width_r) && (row < height_r));

endmodule

// File: logic/pixel_fetch.sv
`timescale 1ns/1ns
`include "blit_params.svh"

module pixel_fetch import blit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  coord_t  sx,
    input  coord_t  sy,
    input  coord_t  px_in,
    input  coord_t  py_in,
    input  addr_t   sheet_base,
    input  coord_t  sheet_width,
    input  depth_t  depth,
    input  logic    gnt,
    input  logic    rvalid,
    input  word_t   rdata,
    input  logic    out_ready,
    output logic    in_ready,
    output logic    req,
    output addr_t   addr,
    output logic    out_valid,
    output colour_t field,
    output coord_t  px_out,
    output coord_t  py_out
);

    localparam int BA_W = `ADDR_W + 3; // bit address

    fetch_state_t    state;
    addr_t           pix_index;
    logic [BA_W-1:0] bit_addr;
    addr_t           word_addr;
    logic            hit;
    logic            take;
    word_t           cache_word;
    addr_t           cache_addr;
    logic            cache_vld;
    logic [4:0]      bit_off;
    depth_t          depth_r;
    logic [5:0]      shift;
    word_t           mask;

    assign pix_index = addr_t'(sx) + addr_t'(sheet_width) * addr_t'(sy);
    assign bit_addr  = {sheet_base, 3'b000} + BA_W'(pix_index) * BA_W'(depth);
    assign word_addr = {bit_addr[BA_W-1:5], 2'b00};
    assign hit       = cache_vld && (cache_addr == word_addr);

    assign in_ready  = state == F_IDLE;
    assign take      = in_valid && in_ready;
    assign out_valid = state == F_HOLD;
    assign addr      = cache_addr; // the pending read is the word being cached

    // msb first, pixel 0 in the top bits
    assign shift = 6'(`WORD_W) - 6'(bit_off) - 6'(depth_r);
    assign mask  = (word_t'(1) << depth_r) - word_t'(1);
    assign field = colour_t'((cache_word >> shift) & mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= F_IDLE;
            req       <= 1'b0;
            cache_vld <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (take) begin
                        if (hit) begin
                            state <= F_HOLD;
                        end else begin
                            state     <= F_READ;
                            req       <= 1'b1;
                            cache_vld <= 1'b0;
                        end
                    end
                end
                F_READ: begin
                    if (gnt) req <= 1'b0;
                    if (rvalid) begin
                        state     <= F_HOLD;
                        cache_vld <= 1'b1;
                    end
                end
                F_HOLD: if (out_ready) state <= F_IDLE;
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            bit_off <= bit_addr[4:0];
            depth_r <= depth;
            px_out  <= px_in;
            py_out  <= py_in;
            if (!hit) cache_addr <= word_addr;
        end
        if (rvalid) cache_word <= rdata;
    end

    // data only comes back for a read that was granted
    a_rd_owner: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> state == F_READ && !req);

endmodule

// File: logic/palette_lookup.sv
`timescale 1ns/1ns
`include "blit_params.svh"

module palette_lookup import blit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  colour_t field,
    input  coord_t  px_in,
    input  coord_t  py_in,
    input  logic    palette_en,
    input  addr_t   palette_base,
    input  logic    gnt,
    input  logic    rvalid,
    input  word_t   rdata,
    output logic    in_ready,
    output logic    req,
    output addr_t   addr,
    output coord_t  fb_x,
    output coord_t  fb_y,
    output colour_t fb_colour,
    output logic    fb_write
);

    logic  holding;
    logic  hi_sel;
    logic  take;
    addr_t entry_addr;

    assign entry_addr = palette_base + (addr_t'(field) << 1); // 2 bytes per entry
    assign in_ready   = !holding;
    assign take       = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            holding  <= 1'b0;
            req      <= 1'b0;
            fb_write <= 1'b0;
        end else begin
            fb_write <= 1'b0;
            if (take && !palette_en) begin
                fb_write <= 1'b1;
            end else if (take) begin
                holding <= 1'b1;
                req     <= 1'b1;
            end
            if (req && gnt) req <= 1'b0;
            if (rvalid) begin
                holding  <= 1'b0;
                fb_write <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fb_x      <= px_in;
            fb_y      <= py_in;
            fb_colour <= field; // replaced on lookup
            addr      <= {entry_addr[`ADDR_W-1:2], 2'b00};
            hi_sel    <= !entry_addr[1]; // even entry sits in the upper half
        end
        if (rvalid) begin
            fb_colour <= hi_sel ? rdata[`WORD_W-1 -: `COLOUR_W] : rdata[`COLOUR_W-1:0];
        end
    end

    // each pixel gets a single strobe
    a_one_write: assert property (@(posedge clk) disable iff (rst)
        fb_write |=> !fb_write || (fb_x != $past(fb_x)) || (fb_y != $past(fb_y)));

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ns
`include "blit_params.svh"

module mem_arbiter import blit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  pal_req,
    input  addr_t pal_addr,
    input  logic  pix_req,
    input  addr_t pix_addr,
    input  word_t mem_rdata,
    output logic  pal_gnt,
    output logic  pix_gnt,
    output logic  pal_rvalid,
    output logic  pix_rvalid,
    output word_t rdata,
    output logic  mem_req,
    output addr_t mem_addr
);

    logic pal_last;
    logic pix_last;

    // palette first, it stalls the whole pipe while it waits
    assign pal_gnt  = pal_req;
    assign pix_gnt  = pix_req && !pal_req;
    assign mem_req  = pal_req || pix_req;
    assign mem_addr = pal_req ? {pal_addr[`ADDR_W-1:2], 2'b00}
                              : {pix_addr[`ADDR_W-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            pal_last <= 1'b0;
            pix_last <= 1'b0;
        end else begin
            pal_last <= pal_gnt;
            pix_last <= pix_gnt;
        end
    end

    assign pal_rvalid = pal_last;
    assign pix_rvalid = pix_last;
    assign rdata      = mem_rdata; // both requesters see the word, rvalid picks the owner

    // a pixel read left waiting keeps its request and address
    a_pix_wait: assert property (@(posedge clk) disable iff (rst)
        pix_req && !pix_gnt |=> pix_req && $stable(pix_addr));

endmodule

// File: logic/blitter_top.sv
`timescale 1ns/1ns
`include "blit_params.svh"

module blitter_top import blit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  addr_t   sheet_base,
    input  coord_t  sheet_width,
    input  coord_t  src_x,
    input  coord_t  src_y,
    input  coord_t  dst_x,
    input  coord_t  dst_y,
    input  coord_t  width,
    input  coord_t  height,
    input  logic    mirror_x,
    input  logic    mirror_y,
    input  depth_t  depth,
    input  logic    palette_en,
    input  addr_t   palette_base,
    input  word_t   mem_rdata,
    output logic    is_busy,
    output logic    mem_req,
    output addr_t   mem_addr,
    output coord_t  fb_x,
    output coord_t  fb_y,
    output colour_t fb_colour,
    output logic    fb_write
);

    coord_t  w_sx;
    coord_t  w_sy;
    coord_t  w_px;
    coord_t  w_py;
    logic    w_valid;
    logic    w_busy;
    logic    f_in_ready;
    logic    f_req;
    addr_t   f_addr;
    logic    f_valid;
    colour_t f_field;
    coord_t  f_px;
    coord_t  f_py;
    logic    p_in_ready;
    logic    p_req;
    addr_t   p_addr;
    logic    pal_gnt;
    logic    pix_gnt;
    logic    pal_rvalid;
    logic    pix_rvalid;
    word_t   rdata;

    // last strobe still counts, so the falling edge comes after it
    assign is_busy = w_busy || !f_in_ready || !p_in_ready || fb_write;

    rect_walker u_walker (
        .clk(clk), .rst(rst), .start(start && !is_busy),
        .src_x(src_x), .src_y(src_y), .dst_x(dst_x), .dst_y(dst_y),
        .width(width), .height(height), .mirror_x(mirror_x), .mirror_y(mirror_y),
        .ready(f_in_ready),
        .sx(w_sx), .sy(w_sy), .px(w_px), .py(w_py), .valid(w_valid), .busy(w_busy)
    );

    pixel_fetch u_fetch (
        .clk(clk), .rst(rst), .in_valid(w_valid),
        .sx(w_sx), .sy(w_sy), .px_in(w_px), .py_in(w_py),
        .sheet_base(sheet_base), .sheet_width(sheet_width), .depth(depth),
        .gnt(pix_gnt), .rvalid(pix_rvalid), .rdata(rdata), .out_ready(p_in_ready),
        .in_ready(f_in_ready), .req(f_req), .addr(f_addr),
        .out_valid(f_valid), .field(f_field), .px_out(f_px), .py_out(f_py)
    );

    palette_lookup u_palette (
        .clk(clk), .rst(rst), .in_valid(f_valid),
        .field(f_field), .px_in(f_px), .py_in(f_py),
        .palette_en(palette_en), .palette_base(palette_base),
        .gnt(pal_gnt), .rvalid(pal_rvalid), .rdata(rdata),
        .in_ready(p_in_ready), .req(p_req), .addr(p_addr),
        .fb_x(fb_x), .fb_y(fb_y), .fb_colour(fb_colour), .fb_write(fb_write)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .pal_req(p_req), .pal_addr(p_addr), .pix_req(f_req), .pix_addr(f_addr),
        .mem_rdata(mem_rdata),
        .pal_gnt(pal_gnt), .pix_gnt(pix_gnt),
        .pal_rvalid(pal_rvalid), .pix_rvalid(pix_rvalid), .rdata(rdata),
        .mem_req(mem_req), .mem_addr(mem_addr)
    );

endmodule

// File: tb/blitter_tb.sv
`timescale 1ns/1ns
`include "blit_params.svh"

module blitter_tb import blit_pkg::*; ();

    localparam int NUM_CMDS = 10;
    localparam int MEM_WORDS = 4096;
    localparam int PAL_BASE = 'h0200;
    localparam int IDLE_LIMIT = 2000; // cycles per row

    typedef struct {
        string  name;
        int     base;
        int     sw;
        int     sx;
        int     sy;
        int     dx;
        int     dy;
        int     w;
        int     h;
        bit     mx;
        bit     my;
        depth_t depth;
        bit     pal;
        int     writes;
    } cmd_t;

    logic    clk;
    logic    rst;
    logic    start;
    addr_t   sheet_base;
    coord_t  sheet_width;
    coord_t  src_x;
    coord_t  src_y;
    coord_t  dst_x;
    coord_t  dst_y;
    coord_t  width;
    coord_t  height;
    logic    mirror_x;
    logic    mirror_y;
    depth_t  depth;
    logic    palette_en;
    addr_t   palette_base;
    word_t   mem_rdata;
    logic    is_busy;
    logic    mem_req;
    addr_t   mem_addr;
    coord_t  fb_x;
    coord_t  fb_y;
    colour_t fb_colour;
    logic    fb_write;

    word_t       mem [0:MEM_WORDS-1];
    cmd_t        cmds [NUM_CMDS];
    logic [47:0] exp_q [$]; // {x, y, colour}
    logic [47:0] exp_pix;
    logic [47:0] got_pix;
    addr_t       exp_rd_q [$]; // word addresses in issue order
    addr_t       exp_rd;
    int          last_word;    // word the fetcher holds
    string       cur_name;
    int          writes_seen;
    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    logic        rd_pend;
    addr_t       rd_addr;

    blitter_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_memory();
        logic [31:0] lfsr;
        word_t       w;
        lfsr = 32'h44f0_7094;
        for (int a = 0; a < MEM_WORDS; a++) begin
            w = '0;
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_next(lfsr);
                w = {w[30:0], lfsr[0]};
            end
            mem[a] = w;
        end
    endtask

    // read port, one cycle of latency
    always @(negedge clk) begin
        rd_pend = mem_req;
        rd_addr = mem_addr;
        @(posedge clk);
        #2;
        if (rd_pend) mem_rdata = mem[rd_addr[13:2]];
    end

    task automatic load_table();
        //         name          base     sw   sx  sy  dx   dy   w  h  mx    my    depth     pal   n
        cmds[0] = '{"d16_plain",  'h1000, 64,  3,  2,  10,  20,  5, 3, 1'b0, 1'b0, DEPTH_16, 1'b0, 15};
        cmds[1] = '{"d8_plain",   'h2000, 80,  7,  1,  100, 50,  6, 2, 1'b0, 1'b0, DEPTH_8,  1'b0, 12};
        cmds[2] = '{"d1_palette", 'h1800, 128, 5,  3,  0,   0,   12, 2, 1'b0, 1'b0, DEPTH_1, 1'b1, 24};
        cmds[3] = '{"d2_palette", 'h1800, 96,  1,  4,  30,  40,  9, 3, 1'b0, 1'b0, DEPTH_2,  1'b1, 27};
        cmds[4] = '{"d4_palette", 'h2400, 64,  2,  2,  200, 100, 7, 2, 1'b0, 1'b0, DEPTH_4,  1'b1, 14};
        cmds[5] = '{"mirror_x",   'h2000, 80,  0,  0,  50,  60,  4, 2, 1'b1, 1'b0, DEPTH_8,  1'b0, 8};
        cmds[6] = '{"mirror_y",   'h2400, 64,  10, 5,  150, 150, 3, 3, 1'b0, 1'b1, DEPTH_4,  1'b1, 9};
        cmds[7] = '{"mirror_xy",  'h1000, 64,  4,  1,  300, 10,  4, 3, 1'b1, 1'b1, DEPTH_16, 1'b0, 12};
        cmds[8] = '{"clip_edges", 'h1000, 64,  0,  0,  396, 237, 8, 6, 1'b0, 1'b0, DEPTH_16, 1'b0, 12};
        cmds[9] = '{"zero_width", 'h1000, 64,  0,  0,  20,  20,  0, 4, 1'b0, 1'b0, DEPTH_8,  1'b0, 0};
    endtask

    // walk, clip, field and palette rules, queued in write order
    task automatic build_expected(input cmd_t c);
        coord_t  sx;
        coord_t  sy;
        coord_t  px;
        coord_t  py;
        longint  ba;
        int      d;
        int      off;
        int      wi;
        int      ea;
        word_t   w;
        word_t   fld;
        colour_t colour;
        d = int'(c.depth);
        for (int j = 0; j < c.h; j++) begin
            for (int i = 0; i < c.w; i++) begin
                sx = coord_t'(c.sx + i);
                sy = coord_t'(c.sy + j);
                px = c.mx ? coord_t'(c.dx + c.w - 1 - i) : coord_t'(c.dx + i);
                py = c.my ? coord_t'(c.dy + c.h - 1 - j) : coord_t'(c.dy + j);
                if (px < `FB_WIDTH && py < `FB_HEIGHT) begin
                    ba  = longint'(c.base) * 8 + (longint'(sx) + longint'(c.sw) * sy) * d;
                    off = int'(ba % 32);
                    wi  = int'(ba >> 5);
                    w   = mem[wi];
                    if (wi != last_word) begin // a repeated word needs no read
                        last_word = wi;
                        exp_rd_q.push_back(addr_t'(wi) << 2);
                    end
                    fld = (w >> (32 - off - d)) & ((word_t'(1) << d) - word_t'(1));
                    if (c.pal) begin
                        ea = PAL_BASE + 2 * int'(fld);
                        w  = mem[ea >> 2];
                        exp_rd_q.push_back(addr_t'(ea >> 2) << 2);
                        colour = ea[1] ? w[15:0] : w[31:16];
                    end else begin
                        colour = colour_t'(fld);
                    end
                    exp_q.push_back({px, py, colour});
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && fb_write) begin
            writes_seen++;
            got_pix = {fb_x, fb_y, fb_colour};
            assert (exp_q.size() != 0) else begin
                $display("unexpected framebuffer write at (%0d,%0d) in %s", fb_x, fb_y, cur_name);
                protocol_errors++;
            end
            if (exp_q.size() != 0) begin
                exp_pix = exp_q.pop_front();
                assert (got_pix == exp_pix) else begin
                    $display("[FAIL] %s: expected (%0d,%0d) %h, actual (%0d,%0d) %h", cur_name,
                             exp_pix[47:32], exp_pix[31:16], exp_pix[15:0],
                             got_pix[47:32], got_pix[31:16], got_pix[15:0]);
                    value_errors++;
                end
            end
        end
    end

    // every cycle with mem_req high is one granted read
    always @(negedge clk) begin
        if (!rst && mem_req) begin
            assert (exp_rd_q.size() != 0) else begin
                $display("unexpected memory read of %h in %s", mem_addr, cur_name);
                protocol_errors++;
            end
            if (exp_rd_q.size() != 0) begin
                exp_rd = exp_rd_q.pop_front();
                assert (mem_addr == exp_rd) else begin
                    $display("[FAIL] %s: expected read %h, actual read %h", cur_name,
                             exp_rd, mem_addr);
                    value_errors++;
                end
            end
        end
    end

    task automatic wait_idle(input int limit, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < limit; n++) begin
            @(negedge clk);
            if (!is_busy) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic run_row(input cmd_t c, output bit ok);
        @(posedge clk);
        #2;
        cur_name     = c.name;
        sheet_base   = addr_t'(c.base);
        sheet_width  = coord_t'(c.sw);
        src_x        = coord_t'(c.sx);
        src_y        = coord_t'(c.sy);
        dst_x        = coord_t'(c.dx);
        dst_y        = coord_t'(c.dy);
        width        = coord_t'(c.w);
        height       = coord_t'(c.h);
        mirror_x     = c.mx;
        mirror_y     = c.my;
        depth        = c.depth;
        palette_en   = c.pal;
        writes_seen  = 0;
        build_expected(c);
        start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        wait_idle(IDLE_LIMIT, ok);
        if (!ok) begin
            $display("is_busy still high after %0d cycles in %s", IDLE_LIMIT, c.name);
            timeouts++;
        end else begin
            assert (writes_seen == c.writes) else begin
                $display("[FAIL] %s: expected %0d writes, actual %0d", c.name, c.writes,
                         writes_seen);
                value_errors++;
            end
            assert (exp_q.size() == 0) else begin
                $display("%s finished with %0d pixels never written", c.name, exp_q.size());
                protocol_errors++;
                exp_q.delete();
            end
            assert (exp_rd_q.size() == 0) else begin
                $display("%s finished with %0d memory reads never issued", c.name,
                         exp_rd_q.size());
                protocol_errors++;
                exp_rd_q.delete();
            end
        end
    endtask

    initial begin
        bit ok;
        rst          = 1'b1;
        start        = 1'b0;
        sheet_base   = '0;
        sheet_width  = '0;
        src_x        = '0;
        src_y        = '0;
        dst_x        = '0;
        dst_y        = '0;
        width        = '0;
        height       = '0;
        mirror_x     = 1'b0;
        mirror_y     = 1'b0;
        depth        = DEPTH_8;
        palette_en   = 1'b0;
        palette_base = addr_t'(PAL_BASE);
        mem_rdata    = '0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        last_word       = -1;
        fill_memory();
        load_table();
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        for (int r = 0; r < NUM_CMDS; r++) begin
            run_row(cmds[r], ok);
            if (!ok) break;
        end
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+logic
logic/blit_pkg.sv
logic/rect_walker.sv
logic/pixel_fetch.sv
logic/palette_lookup.sv
logic/mem_arbiter.sv
logic/blitter_top.sv
tb/blitter_tb.sv

// File: Bender.yml
package:
  name: sprite_blitter

sources:
  - include_dirs:
      - logic
    files:
      - logic/blit_pkg.sv
      - logic/rect_walker.sv
      - logic/pixel_fetch.sv
      - logic/palette_lookup.sv
      - logic/mem_arbiter.sv
      - logic/blitter_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/blitter_tb.sv
